// ==== Makefile ====
# Verilator build and run for the mips_core testbench

VERILATOR ?= verilator
TOP       ?= mips_core_tb
FILELIST  ?= mips_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/alu.sv ====
`timescale 1ns/10ps

module alu
(
    input  mips_ctrl_pkg::alu_op_e  i_alu_op,
    input  mips_isa_pkg::funct_t    i_funct,
    input  mips_isa_pkg::word_t     i_a,
    input  mips_isa_pkg::word_t     i_b,

    output mips_isa_pkg::word_t     o_result,
    output logic                    o_zero
);

    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    alu_fn_e fn;

    // Function select from class and funct
    always_comb
    begin
        case (i_alu_op)
            ALU_OP_ADD: fn = ALU_FN_ADD;
            ALU_OP_SUB: fn = ALU_FN_SUB;
            ALU_OP_FUNCT:
            begin
                case (i_funct)
                    FN_ADD:  fn = ALU_FN_ADD;
                    FN_SUB:  fn = ALU_FN_SUB;
                    FN_AND:  fn = ALU_FN_AND;
                    FN_OR:   fn = ALU_FN_OR;
                    FN_SLT:  fn = ALU_FN_SLT;
                    default: fn = ALU_FN_ZERO;
                endcase
            end
            default: fn = ALU_FN_ZERO;
        endcase
    end

    // Datapath
    always_comb
    begin
        case (fn)
            ALU_FN_ADD: o_result = i_a + i_b;
            ALU_FN_SUB: o_result = i_a - i_b;
            ALU_FN_AND: o_result = i_a & i_b;
            ALU_FN_OR:  o_result = i_a | i_b;
            ALU_FN_SLT: o_result = {31'b0, $signed(i_a) < $signed(i_b)};
            default:    o_result = '0;
        endcase
    end

    // Used by beq after the SUB
    assign o_zero = (o_result == '0);

endmodule

// ==== hw/control_unit.sv ====
`timescale 1ns/10ps

module control_unit
(
    input  logic                    i_instr_valid,
    input  mips_isa_pkg::word_t     i_instruction,

    output logic                    o_reg_dst,
    output logic                    o_branch,
    output logic                    o_mem_write,
    output logic                    o_mem_to_reg,
    output logic                    o_alu_src,
    output logic                    o_reg_write,
    output mips_ctrl_pkg::alu_op_e  o_alu_op,
    output mips_isa_pkg::reg_idx_t  o_rs,
    output mips_isa_pkg::reg_idx_t  o_rt,
    output mips_isa_pkg::reg_idx_t  o_dest,
    output mips_isa_pkg::funct_t    o_funct,
    output mips_isa_pkg::word_t     o_imm
);

    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    instr_u instr;
    logic   funct_known;
    logic   wr_req;

    assign instr = i_instruction;

    // Field extraction
    assign o_rs    = instr.i.rs;
    assign o_rt    = instr.i.rt;
    assign o_funct = instr.r.funct;
    assign o_imm   = {{16{instr.i.imm[15]}}, instr.i.imm};

    // R-type with an unsupported funct writes nothing
    always_comb
    begin
        case (instr.r.funct)
            FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT: funct_known = 1'b1;
            default:                               funct_known = 1'b0;
        endcase
    end

    // Opcode decode, everything inactive when the slot is empty
    always_comb
    begin
        o_reg_dst    = 1'b0;
        o_branch     = 1'b0;
        o_mem_write  = 1'b0;
        o_mem_to_reg = 1'b0;
        o_alu_src    = 1'b0;
        o_alu_op     = ALU_OP_ADD;
        wr_req       = 1'b0;
        if (i_instr_valid)
        begin
            case (instr.i.opcode)
                OP_RTYPE:
                begin
                    o_reg_dst = 1'b1;
                    o_alu_op  = ALU_OP_FUNCT;
                    wr_req    = funct_known;
                end
                OP_ADDI:
                begin
                    o_alu_src = 1'b1;
                    wr_req    = 1'b1;
                end
                OP_LW:
                begin
                    o_alu_src    = 1'b1;
                    o_mem_to_reg = 1'b1;
                    wr_req       = 1'b1;
                end
                OP_SW:
                begin
                    o_alu_src   = 1'b1;
                    o_mem_write = 1'b1;
                end
                OP_BEQ:
                begin
                    o_branch = 1'b1;
                    o_alu_op = ALU_OP_SUB;
                end
                default:
                begin
                    // Unknown opcode, runs as a nop
                end
            endcase
        end
    end

    // rd for R-type, rt otherwise; writes to r0 are dropped here
    assign o_dest      = o_reg_dst ? instr.r.rd : instr.i.rt;
    assign o_reg_write = wr_req && (o_dest != '0);

endmodule

// ==== hw/data_mem.sv ====
`timescale 1ns/10ps

module data_mem
#(
    parameter int DMEM_DEPTH = 64
)
(
    input  logic                i_clk,
    input  logic                i_we,
    input  mips_isa_pkg::word_t i_addr,
    input  mips_isa_pkg::word_t i_wdata,

    output mips_isa_pkg::word_t o_rdata
);

    import mips_isa_pkg::*;

    localparam int AW = $clog2(DMEM_DEPTH);

    word_t           mem [DMEM_DEPTH];
    logic [AW-1:0]   word_idx;

    // Byte address to word index, upper bits wrap
    assign word_idx = i_addr[AW+1:2];

    always_ff @(posedge i_clk)
    begin
        if (i_we)
        begin
            mem[word_idx] <= i_wdata;
        end
    end

    assign o_rdata = mem[word_idx];

endmodule

// ==== hw/mips_core.sv ====
`timescale 1ns/10ps

module mips_core
#(
    parameter int DMEM_DEPTH = 64
)
(
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_instr_valid,
    input  mips_isa_pkg::word_t     i_instruction,

    output mips_isa_pkg::word_t     o_pc,
    output logic                    o_wb_en,
    output mips_isa_pkg::reg_idx_t  o_wb_addr,
    output mips_isa_pkg::word_t     o_wb_data
);

    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    ////////////////////////////////////////////////////////////
    // Interconnect
    ////////////////////////////////////////////////////////////

    logic       branch;
    logic       mem_write;
    logic       mem_to_reg;
    logic       alu_src;
    logic       reg_write;
    alu_op_e    alu_op;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   dest;
    funct_t     funct;
    word_t      imm;
    word_t      rs_data;
    word_t      rt_data;
    word_t      alu_b;
    word_t      alu_result;
    logic       zero;
    word_t      mem_rdata;
    word_t      wb_data;
    logic       take_branch;

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    // Destination select is already folded into o_dest
    control_unit u_control_unit
    (
        .i_instr_valid  (i_instr_valid),
        .i_instruction  (i_instruction),
        .o_reg_dst      (),
        .o_branch       (branch),
        .o_mem_write    (mem_write),
        .o_mem_to_reg   (mem_to_reg),
        .o_alu_src      (alu_src),
        .o_reg_write    (reg_write),
        .o_alu_op       (alu_op),
        .o_rs           (rs),
        .o_rt           (rt),
        .o_dest         (dest),
        .o_funct        (funct),
        .o_imm          (imm)
    );

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////

    assign take_branch = branch & zero;

    pc_unit u_pc_unit
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_advance      (i_instr_valid),
        .i_take_branch  (take_branch),
        .i_imm          (imm),
        .o_pc           (o_pc)
    );

    reg_file u_reg_file
    (
        .i_clk          (i_clk),
        .i_we           (reg_write),
        .i_waddr        (dest),
        .i_wdata        (wb_data),
        .i_raddr_a      (rs),
        .i_raddr_b      (rt),
        .o_rdata_a      (rs_data),
        .o_rdata_b      (rt_data)
    );

    // Immediate for addi, lw, sw
    assign alu_b = alu_src ? imm : rt_data;

    alu u_alu
    (
        .i_alu_op       (alu_op),
        .i_funct        (funct),
        .i_a            (rs_data),
        .i_b            (alu_b),
        .o_result       (alu_result),
        .o_zero         (zero)
    );

    data_mem
    #(
        .DMEM_DEPTH     (DMEM_DEPTH)
    )
    u_data_mem
    (
        .i_clk          (i_clk),
        .i_we           (mem_write),
        .i_addr         (alu_result),
        .i_wdata        (rt_data),
        .o_rdata        (mem_rdata)
    );

    // Write-back mux and report
    assign wb_data   = mem_to_reg ? mem_rdata : alu_result;
    assign o_wb_en   = reg_write;
    assign o_wb_addr = dest;
    assign o_wb_data = wb_data;

endmodule

// ==== hw/mips_ctrl_pkg.sv ====
package mips_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // ALU operation class, from the control unit
    ////////////////////////////////////////////////////////////

    // ADD   address calc for lw/sw, and addi
    // SUB   equality compare for beq
    // FUNCT R-type, the funct field picks the op
    typedef enum logic [1:0] {
        ALU_OP_ADD   = 2'b00,
        ALU_OP_SUB   = 2'b01,
        ALU_OP_FUNCT = 2'b10
    } alu_op_e;

    ////////////////////////////////////////////////////////////
    // ALU function, resolved inside the ALU
    ////////////////////////////////////////////////////////////

    // Zero output for anything not decoded
    typedef enum logic [2:0] {
        ALU_FN_ADD  = 3'd0,
        ALU_FN_SUB  = 3'd1,
        ALU_FN_AND  = 3'd2,
        ALU_FN_OR   = 3'd3,
        ALU_FN_SLT  = 3'd4,
        ALU_FN_ZERO = 3'd7
    } alu_fn_e;

endpackage

// ==== hw/mips_isa_pkg.sv ====
package mips_isa_pkg;

    ////////////////////////////////////////////////////////////
    // Basic word and field types
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // R-type layout, register to register ops
    typedef struct packed {
        opcode_t    opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] shamt;
        funct_t     funct;
    } r_fields_t;

    // I-type layout, immediate, load/store and branch
    typedef struct packed {
        opcode_t     opcode;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm;
    } i_fields_t;

    // Same 32 bits, read either way depending on opcode
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

    ////////////////////////////////////////////////////////////
    // Opcode and funct codes
    ////////////////////////////////////////////////////////////

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_SLT = 6'h2a;

endpackage

// ==== hw/pc_unit.sv ====
`timescale 1ns/10ps

module pc_unit
(
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_advance,
    input  logic                i_take_branch,
    input  mips_isa_pkg::word_t i_imm,

    output mips_isa_pkg::word_t o_pc
);

    import mips_isa_pkg::*;

    word_t pc_reg;
    word_t pc_plus4;
    word_t pc_target;
    word_t pc_next;

    // Sequential and branch candidates
    assign pc_plus4  = pc_reg + 32'd4;
    assign pc_target = pc_plus4 + {i_imm[29:0], 2'b00};
    assign pc_next   = i_take_branch ? pc_target : pc_plus4;

    // Holds while no valid instruction is presented
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            pc_reg <= '0;
        end
        else if (i_advance)
        begin
            pc_reg <= pc_next;
        end
    end

    assign o_pc = pc_reg;

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/10ps

module reg_file
(
    input  logic                    i_clk,
    input  logic                    i_we,
    input  mips_isa_pkg::reg_idx_t  i_waddr,
    input  mips_isa_pkg::word_t     i_wdata,
    input  mips_isa_pkg::reg_idx_t  i_raddr_a,
    input  mips_isa_pkg::reg_idx_t  i_raddr_b,

    output mips_isa_pkg::word_t     o_rdata_a,
    output mips_isa_pkg::word_t     o_rdata_b
);

    import mips_isa_pkg::*;

    word_t regs [32];

    // Write port, r0 is never enabled by the decoder
    always_ff @(posedge i_clk)
    begin
        if (i_we)
        begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // Read ports, r0 hardwired to zero
    always_comb
    begin
        if (i_raddr_a == '0)
        begin
            o_rdata_a = '0;
        end
        else
        begin
            o_rdata_a = regs[i_raddr_a];
        end
    end

    always_comb
    begin
        if (i_raddr_b == '0)
        begin
            o_rdata_b = '0;
        end
        else
        begin
            o_rdata_b = regs[i_raddr_b];
        end
    end

endmodule

// ==== mips_core.f ====
hw/mips_isa_pkg.sv
hw/mips_ctrl_pkg.sv
hw/control_unit.sv
hw/pc_unit.sv
hw/reg_file.sv
hw/alu.sv
hw/data_mem.sv
hw/mips_core.sv
verification/mips_core_chk.sv
verification/mips_core_tb.sv

// ==== verification/mips_core_chk.sv ====
`timescale 1ns/10ps

module mips_core_chk
(
    input logic                i_clk,
    input logic                i_reset,
    input logic                i_instr_valid,
    input mips_isa_pkg::word_t i_pc,
    input logic                i_wb_en,
    input logic                i_mem_write
);

    // Fetch address stays on a word boundary
    pc_aligned: assert property (@(posedge i_clk) disable iff (i_reset)
        i_pc[1:0] == 2'b00)
        else $error("o_pc is not word aligned");

    // Reset clears the pc by the following edge
    pc_after_reset: assert property (@(posedge i_clk)
        i_reset |=> (i_pc == '0))
        else $error("o_pc is not zero after reset");

    // Empty slot, no register write
    no_wb_when_idle: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_instr_valid |-> !i_wb_en)
        else $error("write-back reported while valid is low");

    // Store and register write are exclusive
    wb_xor_store: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_wb_en && i_mem_write))
        else $error("write-back and memory write in the same cycle");

endmodule

bind mips_core mips_core_chk u_chk
(
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_instr_valid  (i_instr_valid),
    .i_pc           (o_pc),
    .i_wb_en        (o_wb_en),
    .i_mem_write    (mem_write)
);

// ==== verification/mips_core_tb.sv ====
`timescale 1ns/10ps

module mips_core_tb;

    import mips_isa_pkg::*;

    localparam int DMEM_DEPTH   = 64;
    localparam int MEM_AW       = $clog2(DMEM_DEPTH);
    localparam int RESET_CYCLES = 16;
    localparam int N_RANDOM     = 400;
    // Reset, fill and 400 random slots, with room for one bubble each
    localparam int CYCLE_LIMIT  = 1000;

    logic     i_clk;
    logic     i_reset;
    logic     i_instr_valid;
    word_t    i_instruction;
    word_t    o_pc;
    logic     o_wb_en;
    reg_idx_t o_wb_addr;
    word_t    o_wb_data;

    integer seed = 87078;
    int     cycle_count = 0;

    // Reference model state
    word_t m_regs    [32];
    word_t m_mem     [DMEM_DEPTH];
    logic  m_written [DMEM_DEPTH];
    word_t m_pc;

    mips_core
    #(
        .DMEM_DEPTH     (DMEM_DEPTH)
    )
    uut
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_instr_valid  (i_instr_valid),
        .i_instruction  (i_instruction),
        .o_pc           (o_pc),
        .o_wb_en        (o_wb_en),
        .o_wb_addr      (o_wb_addr),
        .o_wb_data      (o_wb_data)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    always @(posedge i_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    ////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    ////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected)
        begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t expected, input reg_idx_t actual);
        if (actual !== expected)
        begin
            $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("ERROR at %0t: %s expected %b, got %b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Model helpers and stimulus
    ////////////////////////////////////////////////////////////

    function automatic int rand_below(input int n);
        word_t w;
        w = $random(seed);
        return int'(w % word_t'(n));
    endfunction

    function automatic word_t sext(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    // Word index, byte address over four, wrapped to the memory size
    function automatic logic [MEM_AW-1:0] mem_index(input word_t addr);
        word_t w;
        w = (addr >> 2) % word_t'(DMEM_DEPTH);
        return w[MEM_AW-1:0];
    endfunction

    function automatic word_t random_instr();
        instr_u            ins;
        int                kind;
        logic [MEM_AW-1:0] idx;
        ins  = $random(seed);
        kind = rand_below(16);
        if (kind < 6)
        begin
            ins.r.opcode = OP_RTYPE;
            ins.r.shamt  = '0;
            case (kind)
                0:       ins.r.funct = FN_ADD;
                1:       ins.r.funct = FN_SUB;
                2:       ins.r.funct = FN_AND;
                3:       ins.r.funct = FN_OR;
                4:       ins.r.funct = FN_SLT;
                default: ins.r.funct = 6'(rand_below(16));  // 0x00-0x0f, all unsupported
            endcase
        end
        else if (kind < 9)
        begin
            ins.i.opcode = OP_ADDI;
        end
        else if (kind < 13)
        begin
            // Small word range so loads often hit earlier stores
            ins.i.opcode = (kind < 11) ? OP_LW : OP_SW;
            if (rand_below(2) == 0)
            begin
                ins.i.rs = '0;
            end
            ins.i.imm = 16'(rand_below(16) * 4);
            idx = mem_index(m_regs[ins.i.rs] + sext(ins.i.imm));
            // Never load a word that was not stored yet
            if (ins.i.opcode == OP_LW && !m_written[idx])
            begin
                ins.i.opcode = OP_SW;
            end
        end
        else if (kind < 15)
        begin
            ins.i.opcode = OP_BEQ;
            if (rand_below(2) == 0)
            begin
                ins.i.rt = ins.i.rs;
            end
            ins.i.imm = 16'(rand_below(32) - 16);
        end
        else
        begin
            ins.i.opcode = 6'h30 | 6'(rand_below(16));
        end
        return ins;
    endfunction

    // One slot: predict, drive, check before the edge, then commit the model
    task automatic issue_instr(input logic valid, input word_t word);
        instr_u            ins;
        word_t             a;
        word_t             b;
        word_t             imm;
        word_t             addr;
        word_t             result;
        word_t             next_pc;
        logic              exp_en;
        reg_idx_t          exp_dest;
        logic              do_store;
        logic [MEM_AW-1:0] idx;
        ins      = word;
        a        = m_regs[ins.i.rs];
        b        = m_regs[ins.i.rt];
        imm      = sext(ins.i.imm);
        addr     = a + imm;
        idx      = mem_index(addr);
        exp_en   = 1'b0;
        exp_dest = '0;
        result   = '0;
        do_store = 1'b0;
        next_pc  = valid ? m_pc + 32'd4 : m_pc;
        if (valid)
        begin
            case (ins.i.opcode)
                OP_RTYPE:
                begin
                    exp_dest = ins.r.rd;
                    exp_en   = 1'b1;
                    case (ins.r.funct)
                        FN_ADD:  result = a + b;
                        FN_SUB:  result = a - b;
                        FN_AND:  result = a & b;
                        FN_OR:   result = a | b;
                        FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: exp_en = 1'b0;
                    endcase
                end
                OP_ADDI:
                begin
                    exp_dest = ins.i.rt;
                    exp_en   = 1'b1;
                    result   = addr;
                end
                OP_LW:
                begin
                    exp_dest = ins.i.rt;
                    exp_en   = 1'b1;
                    result   = m_mem[idx];
                end
                OP_SW:   do_store = 1'b1;
                OP_BEQ:
                begin
                    if (a == b)
                    begin
                        next_pc = m_pc + 32'd4 + (imm << 2);
                    end
                end
                default: exp_en = 1'b0;
            endcase
        end
        if (exp_dest == '0)
        begin
            exp_en = 1'b0;
        end

        i_instr_valid = valid;
        i_instruction = word;
        #8;
        check_bit("o_wb_en", exp_en, o_wb_en);
        if (exp_en)
        begin
            check_reg("o_wb_addr", exp_dest, o_wb_addr);
            check_word("o_wb_data", result, o_wb_data);
        end
        check_word("o_pc", m_pc, o_pc);

        if (exp_en)
        begin
            m_regs[exp_dest] = result;
        end
        if (do_store)
        begin
            m_mem[idx]     = b;
            m_written[idx] = 1'b1;
        end
        m_pc = next_pc;
        @(posedge i_clk);
        #1;
    endtask

    // About one slot in eight carries no instruction
    task automatic maybe_bubble();
        if (rand_below(8) == 0)
        begin
            issue_instr(1'b0, $random(seed));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        instr_u ins;
        word_t  w;
        i_reset       = 1'b1;
        i_instr_valid = 1'b0;
        i_instruction = '0;
        m_pc          = '0;
        for (int i = 0; i < 32; i++)
        begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_DEPTH; i++)
        begin
            m_written[i] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge i_clk);
        #1;
        i_reset = 1'b0;

        // Idle right after reset
        issue_instr(1'b0, $random(seed));
        issue_instr(1'b0, $random(seed));

        // addi rN, r0, imm for every register
        for (int i = 1; i < 32; i++)
        begin
            w            = $random(seed);
            ins          = '0;
            ins.i.opcode = OP_ADDI;
            ins.i.rt     = reg_idx_t'(i);
            ins.i.imm    = w[15:0];
            maybe_bubble();
            issue_instr(1'b1, ins);
        end

        for (int n = 0; n < N_RANDOM; n++)
        begin
            maybe_bubble();
            issue_instr(1'b1, random_instr());
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
